// File: glb_pkg.sv
`default_nettype none

package glb_pkg;

    // bank geometry
    localparam int BANK_DATA_WIDTH = 64;
    localparam int GLB_ADDR_WIDTH = 8;
    localparam int BANK_DEPTH = 2 ** GLB_ADDR_WIDTH;
    localparam int NUM_BANKS = 2;
    // request to response, in clock cycles
    localparam int BANK_RD_LATENCY = 2;

    // cgra config bus, addr sits in the upper half of a bank word
    localparam int CGRA_CFG_ADDR_WIDTH = 32;
    localparam int CGRA_CFG_DATA_WIDTH = 32;

    // word count 0..256
    localparam int MAX_NUM_CFGS_WIDTH = 9;

    // dma reads in flight, counter has headroom
    localparam int DMA_OUTST_WIDTH = $clog2(BANK_RD_LATENCY + 2);

    // merge fifos
    localparam int MERGE_FIFO_DEPTH = 8;
    localparam int MERGE_STALL_LEVEL = 4;
    localparam int MERGE_PTR_WIDTH = $clog2(MERGE_FIFO_DEPTH);
    localparam int MERGE_CNT_WIDTH = $clog2(MERGE_FIFO_DEPTH + 1);

    // bank read request
    typedef struct packed {
        logic                      rd_en;
        logic [GLB_ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    // bank read response
    typedef struct packed {
        logic                       rd_data_valid;
        logic [BANK_DATA_WIDTH-1:0] rd_data;
    } rdrs_packet_t;

    // one cgra config register write
    typedef struct packed {
        logic                           cfg_wr_en;
        logic [CGRA_CFG_ADDR_WIDTH-1:0] cfg_addr;
        logic [CGRA_CFG_DATA_WIDTH-1:0] cfg_data;
    } cgra_cfg_t;

    // run description per dma
    typedef struct packed {
        logic [GLB_ADDR_WIDTH-1:0]     start_addr;
        logic [MAX_NUM_CFGS_WIDTH-1:0] num_cfgs;
    } dma_pc_header_t;

    typedef enum logic {
        HOST_WRITE = 1'b0,
        HOST_START = 1'b1
    } host_op_e;

    // host command, bank and addr only matter for writes
    typedef struct packed {
        host_op_e                   op;
        logic                       bank;
        logic [GLB_ADDR_WIDTH-1:0]  addr;
        logic [BANK_DATA_WIDTH-1:0] data;
    } host_cmd_t;

    // host side bank write
    typedef struct packed {
        logic                       wr_en;
        logic [GLB_ADDR_WIDTH-1:0]  wr_addr;
        logic [BANK_DATA_WIDTH-1:0] wr_data;
    } bank_wr_t;

    typedef enum logic [1:0] {
        HC_IDLE = 2'd0,
        HC_RUN  = 2'd1,
        HC_ACK  = 2'd2
    } host_state_e;

    typedef enum logic [1:0] {
        DMA_IDLE  = 2'd0,
        DMA_RUN   = 2'd1,
        DMA_DRAIN = 2'd2
    } dma_state_e;

endpackage

`default_nettype wire

// File: glb_bank.sv
`timescale 1ns/1ps
`default_nettype none

module glb_bank import glb_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    // host write port
    input  bank_wr_t     bank_wr,
    // dma read port, no handshake
    input  rdrq_packet_t rdrq_packet,
    output rdrs_packet_t rdrs_packet
);

    // word storage
    logic [BANK_DATA_WIDTH-1:0] mem [BANK_DEPTH];

    // valid shifts through every read stage
    logic [BANK_RD_LATENCY-1:0] valid_pipe;
    // address lives one stage less than valid
    logic [GLB_ADDR_WIDTH-1:0]  addr_pipe [BANK_RD_LATENCY-1];
    // final registered read data
    logic [BANK_DATA_WIDTH-1:0] rd_data_q;

    // host writes land on the edge after wr_en
    always_ff @(posedge clk) begin
        if (bank_wr.wr_en) begin
            mem[bank_wr.wr_addr] <= bank_wr.wr_data;
        end
    end

    // valid stages
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[BANK_RD_LATENCY-2:0], rdrq_packet.rd_en};
        end
    end

    // address stages, then array read into the data register
    always_ff @(posedge clk) begin
        addr_pipe[0] <= rdrq_packet.rd_addr;
        for (int k = 1; k < BANK_RD_LATENCY - 1; k++) begin
            addr_pipe[k] <= addr_pipe[k-1];
        end
        // only pick up a word when a read is in the last stage
        if (valid_pipe[BANK_RD_LATENCY-2]) begin
            rd_data_q <= mem[addr_pipe[BANK_RD_LATENCY-2]];
        end
    end

    // response lines up exactly BANK_RD_LATENCY cycles after rd_en
    assign rdrs_packet.rd_data_valid = valid_pipe[BANK_RD_LATENCY-1];
    assign rdrs_packet.rd_data = rd_data_q;

endmodule

`default_nettype wire

// File: pc_dma.sv
`timescale 1ns/1ps
`default_nettype none

module pc_dma import glb_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    // run control
    input  logic           pc_start_pulse,
    input  dma_pc_header_t cfg_header,
    // back-pressure from the merge
    input  logic           stall,
    // bank read side
    output rdrq_packet_t   rdrq_packet,
    input  rdrs_packet_t   rdrs_packet,
    // config write stream to the merge
    output cgra_cfg_t      cgra_cfg,
    output logic           dma_done
);

    dma_state_e state;

    // words still to request, next word address
    logic [MAX_NUM_CFGS_WIDTH-1:0] cnt;
    logic [GLB_ADDR_WIDTH-1:0]     addr;

    // registered read request
    logic                      rd_en_q;
    logic [GLB_ADDR_WIDTH-1:0] rd_addr_q;

    // reads sent but not yet answered
    logic [DMA_OUTST_WIDTH-1:0] outstanding;

    // registered response word
    logic                       cfg_valid_q;
    logic [BANK_DATA_WIDTH-1:0] cfg_word_q;

    // one read per cycle unless stalled
    logic issue;

    assign issue = (state == DMA_RUN) && (cnt != '0) && !stall;

    // run fsm, start only taken while idle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= DMA_IDLE;
            cnt   <= '0;
            addr  <= '0;
        end else begin
            case (state)
                DMA_IDLE: begin
                    if (pc_start_pulse) begin
                        state <= DMA_RUN;
                        cnt   <= cfg_header.num_cfgs;
                        addr  <= cfg_header.start_addr;
                    end
                end
                DMA_RUN: begin
                    if (cnt == '0) begin
                        state <= DMA_DRAIN;
                    end else if (issue) begin
                        cnt  <= cnt - 1'b1;
                        // one word per step, wraps inside the bank
                        addr <= addr + 1'b1;
                    end
                end
                DMA_DRAIN: begin
                    // wait for the tail of the read pipeline
                    if (dma_done) begin
                        state <= DMA_IDLE;
                    end
                end
                default: begin
                    state <= DMA_IDLE;
                end
            endcase
        end
    end

    // request valid and in-flight count
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_en_q     <= 1'b0;
            outstanding <= '0;
            cfg_valid_q <= 1'b0;
        end else begin
            rd_en_q     <= issue;
            outstanding <= outstanding + DMA_OUTST_WIDTH'(rd_en_q)
                         - DMA_OUTST_WIDTH'(rdrs_packet.rd_data_valid);
            cfg_valid_q <= rdrs_packet.rd_data_valid;
        end
    end

    // request address and response word
    always_ff @(posedge clk) begin
        rd_addr_q <= addr;
        if (rdrs_packet.rd_data_valid) begin
            cfg_word_q <= rdrs_packet.rd_data;
        end
    end

    assign rdrq_packet.rd_en = rd_en_q;
    assign rdrq_packet.rd_addr = rd_addr_q;

    // upper half is the register address, lower half the data
    assign cgra_cfg.cfg_wr_en = cfg_valid_q;
    assign cgra_cfg.cfg_addr = cfg_word_q[CGRA_CFG_DATA_WIDTH +: CGRA_CFG_ADDR_WIDTH];
    assign cgra_cfg.cfg_data = cfg_word_q[CGRA_CFG_DATA_WIDTH-1:0];

    // done once nothing is in flight and the last write has left
    assign dma_done = (state == DMA_DRAIN) && (outstanding == '0) && !cfg_valid_q;

endmodule

`default_nettype wire

// File: cfg_merge.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_merge import glb_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pc_start_pulse,
    // per-dma streams
    input  cgra_cfg_t            dma_cfg [NUM_BANKS],
    input  logic [NUM_BANKS-1:0] dma_done,
    output logic [NUM_BANKS-1:0] stall,
    // single cgra config bus
    output cgra_cfg_t            cgra_cfg,
    output logic                 pc_done_pulse
);

    // per-source circular buffers
    cgra_cfg_t                  fifo_mem [NUM_BANKS][MERGE_FIFO_DEPTH];
    logic [MERGE_PTR_WIDTH-1:0] wr_ptr [NUM_BANKS];
    logic [MERGE_PTR_WIDTH-1:0] rd_ptr [NUM_BANKS];
    logic [MERGE_CNT_WIDTH-1:0] count [NUM_BANKS];

    logic [NUM_BANKS-1:0] push;
    logic [NUM_BANKS-1:0] pop;
    logic [NUM_BANKS-1:0] nonempty;

    // round-robin pointer to the source served last
    logic last_sel;
    logic sel;

    // sticky per-dma done flags and run state
    logic [NUM_BANKS-1:0] done_flag;
    logic                 run_active;
    logic                 run_finish;
    logic                 pc_done_q;

    // output register
    logic      out_valid;
    cgra_cfg_t out_entry;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            push[i]     = dma_cfg[i].cfg_wr_en;
            nonempty[i] = (count[i] != '0);
            // headroom for words already past the dma's decision point
            stall[i]    = (count[i] >= MERGE_STALL_LEVEL);
        end
        // alternate when both have work and otherwise take whoever has it
        if (&nonempty) begin
            sel = ~last_sel;
        end else begin
            sel = nonempty[1];
        end
        for (int i = 0; i < NUM_BANKS; i++) begin
            pop[i] = (|nonempty) && (sel == 1'(i));
        end
    end

    // fifo storage and the outgoing entry
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (push[i]) begin
                fifo_mem[i][wr_ptr[i]] <= dma_cfg[i];
            end
        end
        if (|pop) begin
            out_entry <= fifo_mem[sel][rd_ptr[sel]];
        end
    end

    // pointers wrap freely since the depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i]  <= '0;
            end
            last_sel  <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                wr_ptr[i] <= wr_ptr[i] + MERGE_PTR_WIDTH'(push[i]);
                rd_ptr[i] <= rd_ptr[i] + MERGE_PTR_WIDTH'(pop[i]);
                count[i]  <= count[i] + MERGE_CNT_WIDTH'(push[i])
                           - MERGE_CNT_WIDTH'(pop[i]);
            end
            if (|pop) begin
                last_sel <= sel;
            end
            out_valid <= |pop;
        end
    end

    // all dmas finished and every buffered word sent
    assign run_finish = run_active && (&done_flag) && !(|nonempty);

    // start wins over a same-cycle done
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_flag  <= '0;
            run_active <= 1'b0;
            pc_done_q  <= 1'b0;
        end else begin
            if (pc_start_pulse) begin
                done_flag  <= '0;
                run_active <= 1'b1;
            end else begin
                done_flag <= done_flag | dma_done;
                if (run_finish) begin
                    run_active <= 1'b0;
                end
            end
            // one pulse per run
            pc_done_q <= run_finish && !pc_start_pulse;
        end
    end

    assign cgra_cfg.cfg_wr_en = out_valid;
    assign cgra_cfg.cfg_addr = out_entry.cfg_addr;
    assign cgra_cfg.cfg_data = out_entry.cfg_data;
    assign pc_done_pulse = pc_done_q;

endmodule

`default_nettype wire

// File: glb_host_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module glb_host_ctrl import glb_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // four-phase command port
    input  logic      host_req,
    input  host_cmd_t host_cmd,
    output logic      host_ack,
    // one write port per bank
    output bank_wr_t  bank_wr [NUM_BANKS],
    // run control
    output logic      pc_start_pulse,
    input  logic      pc_done_pulse
);

    host_state_e state;
    logic        ack_q;

    // command accepted this cycle
    logic req_write;
    logic req_start;

    // only decoded while idle, so each lasts a single cycle
    assign req_write = (state == HC_IDLE) && host_req && (host_cmd.op == HOST_WRITE);
    assign req_start = (state == HC_IDLE) && host_req && (host_cmd.op == HOST_START);

    assign pc_start_pulse = req_start;

    // addr and data fan out, wr_en only to the selected bank
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_wr[i].wr_en   = req_write && (host_cmd.bank == 1'(i));
            bank_wr[i].wr_addr = host_cmd.addr;
            bank_wr[i].wr_data = host_cmd.data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= HC_IDLE;
            ack_q <= 1'b0;
        end else begin
            case (state)
                HC_IDLE: begin
                    if (req_write) begin
                        // bank takes the word on this edge, ack follows
                        state <= HC_ACK;
                    end else if (req_start) begin
                        state <= HC_RUN;
                    end
                end
                HC_RUN: begin
                    // ack the cycle after the run completes
                    if (pc_done_pulse) begin
                        state <= HC_ACK;
                        ack_q <= 1'b1;
                    end
                end
                HC_ACK: begin
                    // hold ack until the host lets go of req
                    if (ack_q && !host_req) begin
                        state <= HC_IDLE;
                        ack_q <= 1'b0;
                    end else begin
                        ack_q <= 1'b1;
                    end
                end
                default: begin
                    state <= HC_IDLE;
                    ack_q <= 1'b0;
                end
            endcase
        end
    end

    assign host_ack = ack_q;

endmodule

`default_nettype wire

// File: glb_pc_top.sv
`timescale 1ns/1ps
`default_nettype none

module glb_pc_top import glb_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    // host command port
    input  logic           host_req,
    input  host_cmd_t      host_cmd,
    // per-dma run headers, held stable during a run
    input  dma_pc_header_t cfg_header [NUM_BANKS],
    output logic           host_ack,
    // merged cgra config bus
    output cgra_cfg_t      cgra_cfg
);

    // host to banks
    bank_wr_t bank_wr [NUM_BANKS];

    // dma to bank and back
    rdrq_packet_t rdrq [NUM_BANKS];
    rdrs_packet_t rdrs [NUM_BANKS];

    // dma to merge
    cgra_cfg_t            dma_cfg [NUM_BANKS];
    logic [NUM_BANKS-1:0] dma_done;
    logic [NUM_BANKS-1:0] stall;

    // run start and completion
    logic pc_start_pulse;
    logic pc_done_pulse;

    glb_host_ctrl host_ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .host_req       (host_req),
        .host_cmd       (host_cmd),
        .host_ack       (host_ack),
        .bank_wr        (bank_wr),
        .pc_start_pulse (pc_start_pulse),
        .pc_done_pulse  (pc_done_pulse)
    );

    // one bank and one dma per lane
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_lane
        glb_bank bank_i (
            .clk         (clk),
            .reset       (reset),
            .bank_wr     (bank_wr[i]),
            .rdrq_packet (rdrq[i]),
            .rdrs_packet (rdrs[i])
        );

        pc_dma dma_i (
            .clk            (clk),
            .reset          (reset),
            .pc_start_pulse (pc_start_pulse),
            .cfg_header     (cfg_header[i]),
            .stall          (stall[i]),
            .rdrq_packet    (rdrq[i]),
            .rdrs_packet    (rdrs[i]),
            .cgra_cfg       (dma_cfg[i]),
            .dma_done       (dma_done[i])
        );
    end

    cfg_merge merge_i (
        .clk            (clk),
        .reset          (reset),
        .pc_start_pulse (pc_start_pulse),
        .dma_cfg        (dma_cfg),
        .dma_done       (dma_done),
        .stall          (stall),
        .cgra_cfg       (cgra_cfg),
        .pc_done_pulse  (pc_done_pulse)
    );

endmodule

`default_nettype wire

// File: tb_glb_pc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_glb_pc import glb_pkg::*; ();

    logic           clk;
    logic           reset;
    logic           host_req;
    host_cmd_t      host_cmd;
    dma_pc_header_t cfg_header [NUM_BANKS];
    logic           host_ack;
    cgra_cfg_t      cgra_cfg;

    // lfsr state
    logic [31:0] lfsr;
    // shadow copy of both banks
    logic [BANK_DATA_WIDTH-1:0] shadow [NUM_BANKS][BANK_DEPTH];
    // expected writes per source in address order
    cgra_cfg_t exp0 [$];
    cgra_cfg_t exp1 [$];
    // writes seen per source in the current run
    logic [MAX_NUM_CFGS_WIDTH-1:0] got_cnt [NUM_BANKS];
    string cur_test;

    glb_pc_top glb_pc_top_i (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .cfg_header (cfg_header),
        .host_ack   (host_ack),
        .cgra_cfg   (cgra_cfg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32 22 2 1 with one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    // cfg_addr is {bank, random, word addr} so sources never collide
    function automatic logic [63:0] make_word(input logic b, input logic [7:0] a);
        logic [22:0] mid;
        logic [31:0] dat;
        mid = 23'(rand_bits(23));
        dat = 32'(rand_bits(32));
        return {b, mid, a, dat};
    endfunction

    task automatic fail_and_stop(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_cfg(input string name, input cgra_cfg_t exp, input cgra_cfg_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            fail_and_stop("config write mismatch");
        end
    endtask

    task automatic check_count(input string name, input logic [MAX_NUM_CFGS_WIDTH-1:0] exp,
                               input logic [MAX_NUM_CFGS_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            fail_and_stop("word count mismatch");
        end
    endtask

    // inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_ack(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (host_ack !== level) begin
            if (n >= limit) begin
                fail_and_stop({"timeout while waiting for ", what});
            end
            next_cycle();
            n++;
        end
    endtask

    // full four-phase write and shadow update
    task automatic host_write(input logic b, input logic [7:0] a, input logic [63:0] d);
        host_cmd.op   = HOST_WRITE;
        host_cmd.bank = b;
        host_cmd.addr = a;
        host_cmd.data = d;
        host_req = 1'b1;
        wait_ack(1'b1, 10, "write ack to rise");
        // ack has to hold while req stays high
        next_cycle();
        if (host_ack !== 1'b1) begin
            fail_and_stop("write ack fell while req was still high");
        end
        host_req = 1'b0;
        wait_ack(1'b0, 4, "write ack to fall");
        shadow[b][a] = d;
    endtask

    task automatic pc_run(input string name, input dma_pc_header_t h0, input dma_pc_header_t h1);
        logic [GLB_ADDR_WIDTH-1:0] a;
        cur_test = name;
        got_cnt[0] = '0;
        got_cnt[1] = '0;
        // expected streams with addresses wrapping inside the bank
        for (int k = 0; k < h0.num_cfgs; k++) begin
            a = h0.start_addr + 8'(k);
            exp0.push_back(cgra_cfg_t'({1'b1, shadow[0][a]}));
        end
        for (int k = 0; k < h1.num_cfgs; k++) begin
            a = h1.start_addr + 8'(k);
            exp1.push_back(cgra_cfg_t'({1'b1, shadow[1][a]}));
        end
        cfg_header[0] = h0;
        cfg_header[1] = h1;
        host_cmd.op   = HOST_START;
        host_cmd.bank = 1'b0;
        host_cmd.addr = '0;
        host_cmd.data = '0;
        host_req = 1'b1;
        wait_ack(1'b1, 4000, "run ack to rise");
        // everything must be out by ack
        check_count({name, " bank0 count"}, h0.num_cfgs, got_cnt[0]);
        check_count({name, " bank1 count"}, h1.num_cfgs, got_cnt[1]);
        check_count({name, " bank0 left"}, '0, 9'(exp0.size()));
        check_count({name, " bank1 left"}, '0, 9'(exp1.size()));
        host_req = 1'b0;
        wait_ack(1'b0, 4, "run ack to fall");
        repeat (5) next_cycle();
    endtask

    function automatic dma_pc_header_t rand_header(input int max_cnt);
        dma_pc_header_t h;
        h.start_addr = 8'(rand_bits(8));
        h.num_cfgs   = 9'(rand_bits(9) % (max_cnt + 1));
        return h;
    endfunction

    // output checker sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && cgra_cfg.cfg_wr_en === 1'b1) begin
            if (cgra_cfg.cfg_addr[31] == 1'b0) begin
                if (exp0.size() == 0) begin
                    fail_and_stop({cur_test, ": unexpected write from bank 0"});
                end
                check_cfg(cur_test, exp0[0], cgra_cfg);
                void'(exp0.pop_front());
                got_cnt[0] = got_cnt[0] + 1'b1;
            end else begin
                if (exp1.size() == 0) begin
                    fail_and_stop({cur_test, ": unexpected write from bank 1"});
                end
                check_cfg(cur_test, exp1[0], cgra_cfg);
                void'(exp1.pop_front());
                got_cnt[1] = got_cnt[1] + 1'b1;
            end
        end
    end

    initial begin
        dma_pc_header_t h0;
        dma_pc_header_t h1;
        logic           b;
        logic [7:0]     a;
        lfsr          = 32'h8acd;
        cur_test      = "reset";
        reset         = 1'b1;
        host_req      = 1'b0;
        host_cmd      = '0;
        cfg_header[0] = '0;
        cfg_header[1] = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        // idle bus after reset
        cur_test = "idle";
        repeat (20) begin
            next_cycle();
            if (host_ack !== 1'b0) begin
                fail_and_stop("host_ack is high with no request");
            end
        end

        // fill every word and then overwrite at random
        cur_test = "host_write";
        for (int bb = 0; bb < NUM_BANKS; bb++) begin
            for (int aa = 0; aa < BANK_DEPTH; aa++) begin
                host_write(1'(bb), 8'(aa), make_word(1'(bb), 8'(aa)));
            end
        end
        repeat (40) begin
            b = 1'(rand_bits(1));
            a = 8'(rand_bits(8));
            host_write(b, a, make_word(b, a));
        end

        // one side empty
        h0 = '0;
        h1 = rand_header(64);
        pc_run("single_bank1", h0, h1);
        h0 = rand_header(64);
        h1 = '0;
        pc_run("single_bank0", h0, h1);

        // both dmas at once
        repeat (4) begin
            pc_run("parallel", rand_header(40), rand_header(40));
        end

        // long runs keep the merge stalling
        h0 = rand_header(0);
        h1 = rand_header(0);
        h0.num_cfgs = 9'(256 - rand_bits(3));
        h1.num_cfgs = 9'(256 - rand_bits(3));
        pc_run("backpressure", h0, h1);

        // empty run then a fresh one
        pc_run("empty", '0, '0);
        pc_run("after_empty", rand_header(40), rand_header(40));

        if (exp0.size() != 0 || exp1.size() != 0) begin
            fail_and_stop("expected writes left over at end of test");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
glb_pkg.sv
glb_bank.sv
pc_dma.sv
cfg_merge.sv
glb_host_ctrl.sv
glb_pc_top.sv
tb_glb_pc.sv
